/* verilog.f */
verilog/icache_pkg.sv
verilog/mem_pkg.sv
verilog/fetch_port.sv
verilog/icache_core.sv
verilog/data_sram.sv
verilog/refill_port.sv
verilog/icache_top.sv
dv/icache_chk.sv
dv/icache_tb.sv

/* Makefile */
VERILATOR  ?= verilator
FILELIST   := verilog.f
TB_TOP     := icache_tb
RTL_TOP    := icache_top
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := all tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/icache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_tb;
    import icache_pkg::*;
    import mem_pkg::*;

    // requests issued by tests 2 to 6
    localparam int NUM_REQS       = 16 + 33 + 8 + 4 + 400;
    localparam int TIMEOUT_CYCLES = 20 * NUM_REQS + 2000;

    logic                  clk;
    logic                  rst;
    logic                  req_valid;
    fetch_addr_u           req_pc;
    logic                  credit_return;
    logic                  resp_valid;
    logic [WORD_W-1:0]     resp_data;
    logic                  mem_req_valid;
    logic [MEM_ADDR_W-1:0] mem_req_addr;
    logic                  mem_credit;
    logic                  mem_resp_valid;
    logic [MEM_DATA_W-1:0] mem_resp_data;

    int unsigned cyc = 0;
    int errors = 0;
    int checks = 0;
    int tests_run = 0;
    int tests_bad = 0;
    int test_err0 = 0;
    int core_credits = FETCH_CREDITS;
    int outstanding = 0;
    int credits_owed = 0;
    int mem_reqs = 0;
    int model_misses = 0;
    int resp_count = 0;
    int last_latency = 0;
    bit hold_credit = 1'b0;

    logic [WORD_W-1:0]     exp_word_q [$];
    int unsigned           issue_cyc_q [$];
    logic [MEM_ADDR_W-1:0] exp_miss_q [$];
    logic [MEM_ADDR_W-1:0] mem_addr_q [$];
    int unsigned           mem_due_q [$];

    // tag, valid and round-robin state of the cache model
    logic [TAG_W-1:0] m_tag [NUM_WAYS][NUM_SETS];
    logic             m_valid [NUM_WAYS][NUM_SETS];
    logic             m_rr [NUM_SETS];

    icache_top i_dut (
        .clk            (clk),
        .rst            (rst),
        .req_valid      (req_valid),
        .req_pc         (req_pc),
        .credit_return  (credit_return),
        .resp_valid     (resp_valid),
        .resp_data      (resp_data),
        .mem_req_valid  (mem_req_valid),
        .mem_req_addr   (mem_req_addr),
        .mem_credit     (mem_credit),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_data  (mem_resp_data)
    );

    bind refill_port icache_chk i_chk (
        .clk           (clk),
        .rst           (rst),
        .miss_req      (miss_req),
        .refill_done   (refill_done),
        .mem_req_valid (mem_req_valid),
        .mem_credit    (mem_credit),
        .credit_cnt    (credit_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // expected instruction word, a fixed mix of its pc
    function automatic logic [WORD_W-1:0] word_for_pc(input logic [WORD_W-1:0] pc);
        return (pc * 32'h9e37_79b1) ^ {pc[7:0], pc[31:8]} ^ 32'h6b43_a9d5;
    endfunction

    function automatic logic [MEM_DATA_W-1:0] line_data(input logic [MEM_ADDR_W-1:0] addr);
        return {word_for_pc({addr, 3'b100}), word_for_pc({addr, 3'b000})};
    endfunction

    function automatic logic [WORD_W-1:0] make_pc(input logic [TAG_W-1:0] tag,
                                                  input logic [INDEX_W-1:0] index,
                                                  input logic word);
        fetch_addr_u a;
        a.f.tag    = tag;
        a.f.index  = index;
        a.f.offset = {word, 2'b00};
        return a.pc;
    endfunction

    // returns 1 on a predicted miss and updates the model like a fill
    function automatic bit model_access(input logic [WORD_W-1:0] pc);
        fetch_addr_u a;
        logic        hit;
        logic        way;
        a.pc = pc;
        hit  = 1'b0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (m_valid[w][a.f.index] && m_tag[w][a.f.index] == a.f.tag) begin
                hit = 1'b1;
            end
        end
        if (!hit) begin
            if (m_valid[0][a.f.index] && !m_valid[1][a.f.index]) begin
                way = 1'b1;
            end else if (!m_valid[0][a.f.index] && m_valid[1][a.f.index]) begin
                way = 1'b0;
            end else begin
                way = m_rr[a.f.index];
            end
            m_tag[way][a.f.index]   = a.f.tag;
            m_valid[way][a.f.index] = 1'b1;
            m_rr[a.f.index]         = ~m_rr[a.f.index];
            exp_miss_q.push_back({a.f.tag, a.f.index});
        end
        return !hit;
    endfunction

    task automatic check_eq(input logic [63:0] got, input logic [63:0] expected,
                            input string what);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("MISMATCH at %0t: %s, got %0h expected %0h", $time, what, got, expected);
        end
    endtask

    task automatic report_fault(input string what);
        errors++;
        $display("ERROR at %0t: %s", $time, what);
    endtask

    // called 1 ns after a rising edge, returns at the same phase
    task automatic send_pc(input logic [WORD_W-1:0] pc);
        while (core_credits == 0) begin
            @(posedge clk);
            #1;
        end
        if (model_access(pc)) begin
            model_misses++;
        end
        exp_word_q.push_back(word_for_pc(pc));
        issue_cyc_q.push_back(cyc);
        req_valid    = 1'b1;
        req_pc.pc    = pc;
        core_credits = core_credits - 1;
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic wait_drained();
        while (exp_word_q.size() != 0 || credits_owed != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic finish_test(input int num, input string name);
        tests_run++;
        if (errors != test_err0) begin
            tests_bad++;
        end
        $display("test %0d %s: %s", num, name, (errors == test_err0) ? "ok" : "FAIL");
        test_err0 = errors;
    endtask

    // memory with credit return, answers after 2 to 6 cycles
    initial begin : memory_model
        logic [MEM_ADDR_W-1:0] line_addr;
        bit                    hold_now;
        mem_credit     = 1'b0;
        mem_resp_valid = 1'b0;
        mem_resp_data  = '0;
        forever begin
            @(negedge clk);
            hold_now = hold_credit;
            if (!rst && mem_req_valid) begin
                mem_reqs++;
                outstanding++;
                check_eq(64'(outstanding <= MEM_CREDITS), 64'(1),
                         "memory request within advertised credits");
                if (exp_miss_q.size() == 0) begin
                    report_fault("memory request with no miss predicted by the model");
                end else begin
                    check_eq(64'(mem_req_addr), 64'(exp_miss_q.pop_front()),
                             "memory request line address");
                end
                mem_addr_q.push_back(mem_req_addr);
                mem_due_q.push_back(cyc + $urandom_range(6, 2));
            end
            @(posedge clk);
            #1;
            mem_resp_valid = 1'b0;
            mem_credit     = 1'b0;
            if (mem_due_q.size() != 0 && mem_due_q[0] <= cyc) begin
                line_addr = mem_addr_q.pop_front();
                void'(mem_due_q.pop_front());
                mem_resp_data  = line_data(line_addr);
                mem_resp_valid = 1'b1;
                credits_owed++;
            end
            if (!hold_now && credits_owed != 0) begin
                mem_credit = 1'b1;
                credits_owed--;
                outstanding--;
            end
        end
    end

    initial begin : compare_responses
        logic [WORD_W-1:0] exp_word;
        int unsigned       issued;
        forever begin
            @(negedge clk);
            if (!rst && credit_return) begin
                core_credits = core_credits + 1;
                check_eq(64'(core_credits <= FETCH_CREDITS), 64'(1),
                         "core credits within queue depth");
            end
            if (!rst && resp_valid) begin
                resp_count++;
                if (exp_word_q.size() == 0) begin
                    report_fault("response arrived with no request outstanding");
                end else begin
                    exp_word     = exp_word_q.pop_front();
                    issued       = issue_cyc_q.pop_front();
                    last_latency = int'(cyc - issued);
                    check_eq(64'(resp_data), 64'(exp_word), "response word");
                end
            end
        end
    end

    initial begin
        while (cyc < TIMEOUT_CYCLES) begin
            @(negedge clk);
        end
        $display("timeout: run did not complete within %0d cycles", TIMEOUT_CYCLES);
        $display("tests failed");
        $finish;
    end

    initial begin : main_seq
        int unsigned seed_ret;
        int          reqs0;
        int          miss0;
        int          resp0;
        int          k;
        int          conflict_seq [8];
        seed_ret     = $urandom(32'h3e49903a);
        conflict_seq = '{0, 1, 2, 0, 2, 1, 0, 0};
        rst       = 1'b1;
        req_valid = 1'b0;
        req_pc    = '0;
        for (int s = 0; s < NUM_SETS; s++) begin
            m_valid[0][s] = 1'b0;
            m_valid[1][s] = 1'b0;
            m_rr[s]       = 1'b0;
        end
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        repeat (20) begin
            @(negedge clk);
            check_eq(64'({credit_return, resp_valid, mem_req_valid}), 64'(0),
                     "outputs idle after reset");
        end
        check_eq(64'(core_credits), 64'(FETCH_CREDITS), "core credits after reset");
        @(posedge clk);
        #1;
        finish_test(1, "idle after reset");

        reqs0 = mem_reqs;
        for (int i = 0; i < 16; i++) begin
            send_pc(make_pc(TAG_W'(32'h100 + i), INDEX_W'(i * 4), 1'(i)));
        end
        wait_drained();
        check_eq(64'(mem_reqs - reqs0), 64'(16), "memory requests for cold misses");
        finish_test(2, "cold misses");

        reqs0 = mem_reqs;
        for (int i = 0; i < 16; i++) begin
            for (int w = 0; w < 2; w++) begin
                send_pc(make_pc(TAG_W'(32'h100 + i), INDEX_W'(i * 4), 1'(w)));
            end
        end
        wait_drained();
        check_eq(64'(mem_reqs - reqs0), 64'(0), "memory requests on hits");
        send_pc(make_pc(TAG_W'(32'h105), INDEX_W'(20), 1'b1));
        wait_drained();
        check_eq(64'(last_latency), 64'(2), "isolated hit latency");
        finish_test(3, "hits");

        reqs0 = mem_reqs;
        miss0 = model_misses;
        for (int n = 0; n < 8; n++) begin
            send_pc(make_pc(TAG_W'(32'h2a000 + conflict_seq[n] * 32'h1000), INDEX_W'(50),
                            1'(n)));
        end
        wait_drained();
        check_eq(64'(mem_reqs - reqs0), 64'(5), "round-robin misses in one set");
        check_eq(64'(mem_reqs - reqs0), 64'(model_misses - miss0), "conflict memory requests");
        finish_test(4, "conflicts");

        // withhold memory credits, only the advertised ones may be used
        reqs0       = mem_reqs;
        resp0       = resp_count;
        hold_credit = 1'b1;
        for (int i = 0; i < 4; i++) begin
            send_pc(make_pc(TAG_W'(32'h3f0 + i), INDEX_W'(40 + i), 1'(i)));
        end
        while (resp_count - resp0 < MEM_CREDITS) begin
            @(posedge clk);
            #1;
        end
        repeat (30) @(posedge clk);
        #1;
        check_eq(64'(mem_reqs - reqs0), 64'(MEM_CREDITS), "memory requests without credit");
        check_eq(64'(resp_count - resp0), 64'(MEM_CREDITS), "responses without credit");
        hold_credit = 1'b0;
        wait_drained();
        check_eq(64'(mem_reqs - reqs0), 64'(4), "memory requests after credit release");
        finish_test(5, "credit starvation");

        reqs0 = mem_reqs;
        miss0 = model_misses;
        for (int n = 0; n < 400; n++) begin
            k = int'($urandom_range(23));
            send_pc(make_pc(TAG_W'(32'h500 + k / 8), INDEX_W'(8 + k % 8),
                            1'($urandom_range(1))));
        end
        wait_drained();
        check_eq(64'(mem_reqs - reqs0), 64'(model_misses - miss0), "random stream misses");
        finish_test(6, "random stream");

        $display("summary: %0d tests run, %0d failing, %0d checks, %0d errors",
                 tests_run, tests_bad, checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dv/icache_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_chk (
    input logic                             clk,
    input logic                             rst,
    input logic                             miss_req,
    input logic                             refill_done,
    input logic                             mem_req_valid,
    input logic                             mem_credit,
    input logic [mem_pkg::MEM_CREDIT_W-1:0] credit_cnt
);
    import mem_pkg::*;

    // set by a memory request, cleared when its refill completes
    logic req_in_flight;

    // requests on the bus not yet paid back by a memory credit
    logic [MEM_CREDIT_W-1:0] reqs_out;

    always_ff @(posedge clk) begin
        if (rst) begin
            req_in_flight <= 1'b0;
        end else if (refill_done) begin
            req_in_flight <= 1'b0;
        end else if (mem_req_valid) begin
            req_in_flight <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            reqs_out <= '0;
        end else if (mem_req_valid && !mem_credit) begin
            reqs_out <= reqs_out + 1'b1;
        end else if (mem_credit && !mem_req_valid) begin
            reqs_out <= reqs_out - 1'b1;
        end
    end

    a_credit_bound: assert property (@(posedge clk) disable iff (rst)
        credit_cnt <= MEM_CREDIT_W'(MEM_CREDITS))
        else $error("memory credit count above the advertised credits");

    a_req_needs_credit: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid |-> (reqs_out < MEM_CREDIT_W'(MEM_CREDITS)))
        else $error("memory request issued with no credit held");

    a_one_req_per_miss: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid |-> (miss_req && !req_in_flight))
        else $error("second memory request before the refill completed");

    a_req_pulse: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid |=> !mem_req_valid)
        else $error("memory request held for more than one cycle");

endmodule

`default_nettype wire

/* verilog/icache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_top (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           req_valid,
    input  icache_pkg::fetch_addr_u        req_pc,
    output logic                           credit_return,
    output logic                           resp_valid,
    output logic [icache_pkg::WORD_W-1:0]  resp_data,
    output logic                           mem_req_valid,
    output logic [mem_pkg::MEM_ADDR_W-1:0] mem_req_addr,
    input  logic                           mem_credit,
    input  logic                           mem_resp_valid,
    input  logic [mem_pkg::MEM_DATA_W-1:0] mem_resp_data
);
    import icache_pkg::*;
    import mem_pkg::*;

    logic                  head_valid;
    fetch_addr_u           head_addr;
    logic                  head_take;

    logic                  sram_en;
    logic                  sram_we;
    logic [INDEX_W-1:0]    sram_addr;
    logic [SRAM_W-1:0]     sram_wdata;
    logic [SRAM_W-1:0]     sram_wmask;
    logic [SRAM_W-1:0]     sram_rdata;

    logic                  miss_req;
    logic [MEM_ADDR_W-1:0] miss_line_addr;
    logic                  refill_done;
    logic [MEM_DATA_W-1:0] refill_line;

    fetch_port u_fetch_port (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req_pc        (req_pc),
        .credit_return (credit_return),
        .head_valid    (head_valid),
        .head_addr     (head_addr),
        .head_take     (head_take)
    );

    icache_core u_icache_core (
        .clk            (clk),
        .rst            (rst),
        .head_valid     (head_valid),
        .head_addr      (head_addr),
        .head_take      (head_take),
        .sram_en        (sram_en),
        .sram_we        (sram_we),
        .sram_addr      (sram_addr),
        .sram_wdata     (sram_wdata),
        .sram_wmask     (sram_wmask),
        .sram_rdata     (sram_rdata),
        .miss_req       (miss_req),
        .miss_line_addr (miss_line_addr),
        .refill_done    (refill_done),
        .refill_line    (refill_line),
        .resp_valid     (resp_valid),
        .resp_data      (resp_data)
    );

    data_sram u_data_sram (
        .clk   (clk),
        .en    (sram_en),
        .we    (sram_we),
        .addr  (sram_addr),
        .wdata (sram_wdata),
        .wmask (sram_wmask),
        .rdata (sram_rdata)
    );

    refill_port u_refill_port (
        .clk            (clk),
        .rst            (rst),
        .miss_req       (miss_req),
        .miss_line_addr (miss_line_addr),
        .refill_done    (refill_done),
        .refill_line    (refill_line),
        .mem_req_valid  (mem_req_valid),
        .mem_req_addr   (mem_req_addr),
        .mem_credit     (mem_credit),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_data  (mem_resp_data)
    );

endmodule

`default_nettype wire

/* verilog/refill_port.sv */
`timescale 1ns/1ps
`default_nettype none

module refill_port (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           miss_req,
    input  logic [mem_pkg::MEM_ADDR_W-1:0] miss_line_addr,
    output logic                           refill_done,
    output logic [mem_pkg::MEM_DATA_W-1:0] refill_line,
    output logic                           mem_req_valid,
    output logic [mem_pkg::MEM_ADDR_W-1:0] mem_req_addr,
    input  logic                           mem_credit,
    input  logic                           mem_resp_valid,
    input  logic [mem_pkg::MEM_DATA_W-1:0] mem_resp_data
);
    import mem_pkg::*;

    logic [MEM_CREDIT_W-1:0] credit_cnt;
    logic                    pending;
    logic [MEM_DATA_W-1:0]   line_buf;

    // one request per miss, and only with a credit in hand
    assign mem_req_valid = miss_req & ~pending & (credit_cnt != '0);
    assign mem_req_addr  = miss_line_addr;
    assign refill_line   = line_buf;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (refill_done) begin
            pending <= 1'b0;
        end else if (mem_req_valid) begin
            pending <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            credit_cnt <= MEM_CREDIT_W'(MEM_CREDITS);
        end else begin
            case ({mem_req_valid, mem_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    // response always accepted, only one refill can be in flight
    always_ff @(posedge clk) begin
        if (mem_resp_valid) begin
            line_buf <= mem_resp_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            refill_done <= 1'b0;
        end else begin
            refill_done <= mem_resp_valid;
        end
    end

endmodule

`default_nettype wire

/* verilog/data_sram.sv */
`timescale 1ns/1ps
`default_nettype none

module data_sram (
    input  logic                           clk,
    input  logic                           en,
    input  logic                           we,
    input  logic [icache_pkg::INDEX_W-1:0] addr,
    input  logic [icache_pkg::SRAM_W-1:0]  wdata,
    input  logic [icache_pkg::SRAM_W-1:0]  wmask,
    output logic [icache_pkg::SRAM_W-1:0]  rdata
);
    import icache_pkg::*;

    // way 0 in the low half of each row
    logic [SRAM_W-1:0] mem [NUM_SETS];

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                // bit-write mask, a set bit means write
                mem[addr] <= (mem[addr] & ~wmask) | (wdata & wmask);
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/icache_core.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_core (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           head_valid,
    input  icache_pkg::fetch_addr_u        head_addr,
    output logic                           head_take,
    output logic                           sram_en,
    output logic                           sram_we,
    output logic [icache_pkg::INDEX_W-1:0] sram_addr,
    output logic [icache_pkg::SRAM_W-1:0]  sram_wdata,
    output logic [icache_pkg::SRAM_W-1:0]  sram_wmask,
    input  logic [icache_pkg::SRAM_W-1:0]  sram_rdata,
    output logic                           miss_req,
    output logic [mem_pkg::MEM_ADDR_W-1:0] miss_line_addr,
    input  logic                           refill_done,
    input  logic [icache_pkg::LINE_W-1:0]  refill_line,
    output logic                           resp_valid,
    output logic [icache_pkg::WORD_W-1:0]  resp_data
);
    import icache_pkg::*;

    logic [ST_W-1:0]     state;
    fetch_addr_u         req_q;
    logic [INDEX_W-1:0]  idx;

    logic [TAG_W-1:0]    tag_mem [NUM_WAYS][NUM_SETS];
    logic [NUM_SETS-1:0] valid_bits [NUM_WAYS];
    logic [NUM_SETS-1:0] rr_bits;

    logic [TAG_W-1:0]    rd_tag [NUM_WAYS];
    logic [NUM_WAYS-1:0] rd_valid;

    logic [NUM_WAYS-1:0] way_hit;
    logic                hit;
    logic [WAY_W-1:0]    hit_way;
    logic [WAY_W-1:0]    fill_way;
    logic [LINE_W-1:0]   hit_line;
    logic [LINE_W-1:0]   sel_line;

    assign idx = req_q.f.index;

    assign head_take = (state == ST_IDLE) & head_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (head_take) begin
                        state <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: begin
                    state <= hit ? ST_IDLE : ST_MISS;
                end
                ST_MISS: begin
                    if (refill_done) begin
                        state <= ST_FILL;
                    end
                end
                ST_FILL: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // request latch and tag read, same edge as the data SRAM read
    always_ff @(posedge clk) begin
        if (head_take) begin
            req_q <= head_addr;
            for (int w = 0; w < NUM_WAYS; w++) begin
                rd_tag[w]   <= tag_mem[w][head_addr.f.index];
                rd_valid[w] <= valid_bits[w][head_addr.f.index];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_FILL) begin
            tag_mem[fill_way][idx] <= req_q.f.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                valid_bits[w] <= '0;
            end
            rr_bits <= '0;
        end else if (state == ST_FILL) begin
            valid_bits[fill_way][idx] <= 1'b1;
            rr_bits[idx]              <= ~rr_bits[idx];
        end
    end

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_hit[w] = rd_valid[w] & (rd_tag[w] == req_q.f.tag);
            if (way_hit[w]) begin
                hit_way = WAY_W'(w);
            end
        end
        hit = |way_hit;
    end

    // a lone invalid way wins over the round-robin pick
    always_comb begin
        if (rd_valid[0] & ~rd_valid[1]) begin
            fill_way = 1'b1;
        end else if (~rd_valid[0] & rd_valid[1]) begin
            fill_way = 1'b0;
        end else begin
            fill_way = rr_bits[idx];
        end
    end

    assign hit_line = sram_rdata[hit_way*LINE_W +: LINE_W];
    assign sel_line = (state == ST_FILL) ? refill_line : hit_line;

    // offset bit 2 picks the word within the line
    assign resp_data  = sel_line[req_q.f.offset[OFFSET_W-1]*WORD_W +: WORD_W];
    assign resp_valid = ((state == ST_LOOKUP) & hit) | (state == ST_FILL);

    assign sram_en    = head_take | (state == ST_FILL);
    assign sram_we    = (state == ST_FILL);
    assign sram_addr  = (state == ST_IDLE) ? head_addr.f.index : idx;
    assign sram_wdata = {NUM_WAYS{refill_line}};

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            sram_wmask[w*LINE_W +: LINE_W] = {LINE_W{fill_way == WAY_W'(w)}};
        end
    end

    assign miss_req       = (state == ST_MISS);
    assign miss_line_addr = {req_q.f.tag, req_q.f.index};

endmodule

`default_nettype wire

/* verilog/fetch_port.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_port (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_valid,
    input  icache_pkg::fetch_addr_u req_pc,
    output logic                    credit_return,
    output logic                    head_valid,
    output icache_pkg::fetch_addr_u head_addr,
    input  logic                    head_take
);
    import icache_pkg::*;
    import mem_pkg::*;

    fetch_addr_u            queue_mem [FETCH_CREDITS];
    logic [FETCH_PTR_W-1:0] wr_ptr;
    logic [FETCH_PTR_W-1:0] rd_ptr;
    logic [FETCH_CNT_W-1:0] count;
    logic                   push;
    logic                   pop;

    // core only sends while it holds a credit, so a push never overflows
    assign push = req_valid;
    assign pop  = head_take & head_valid;

    assign head_valid = (count != '0);
    assign head_addr  = queue_mem[rd_ptr];

    // one credit back per entry leaving the queue
    assign credit_return = pop;

    always_ff @(posedge clk) begin
        if (push) begin
            queue_mem[wr_ptr] <= req_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                if (wr_ptr == FETCH_PTR_W'(FETCH_CREDITS - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (pop) begin
                if (rd_ptr == FETCH_PTR_W'(FETCH_CREDITS - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    // line address is tag plus index
    localparam int MEM_ADDR_W = 29;
    localparam int MEM_DATA_W = 64;

    // request slots advertised by memory after reset
    localparam int MEM_CREDITS  = 2;
    localparam int MEM_CREDIT_W = $clog2(MEM_CREDITS + 1);

    // input queue depth, also the core's starting credit count
    localparam int FETCH_CREDITS = 2;
    localparam int FETCH_PTR_W   = $clog2(FETCH_CREDITS);
    localparam int FETCH_CNT_W   = $clog2(FETCH_CREDITS + 1);

endpackage

`default_nettype wire

/* verilog/icache_pkg.sv */
`default_nettype none

package icache_pkg;

    // cache geometry
    localparam int TAG_W    = 23;
    localparam int INDEX_W  = 6;
    localparam int OFFSET_W = 3;
    localparam int NUM_SETS = 64;
    localparam int NUM_WAYS = 2;
    localparam int WAY_W    = $clog2(NUM_WAYS);
    localparam int LINE_W   = 64;
    localparam int WORD_W   = 32;

    // one SRAM row holds every way of a set
    localparam int SRAM_W = NUM_WAYS * LINE_W;

    // lookup/refill FSM encoding
    localparam int ST_W = 2;
    localparam logic [ST_W-1:0] ST_IDLE   = 2'd0;
    localparam logic [ST_W-1:0] ST_LOOKUP = 2'd1;
    localparam logic [ST_W-1:0] ST_MISS   = 2'd2;
    localparam logic [ST_W-1:0] ST_FILL   = 2'd3;

    // fetch address, a flat pc to the core and split fields to the cache
    typedef union packed {
        logic [WORD_W-1:0] pc;
        struct packed {
            logic [TAG_W-1:0]    tag;
            logic [INDEX_W-1:0]  index;
            logic [OFFSET_W-1:0] offset;
        } f;
    } fetch_addr_u;

endpackage

`default_nettype wire
